// File: vlog.f
source/core_isa_pkg.sv
source/core_pipe_pkg.sv
source/core_fetch.sv
source/core_regfile.sv
source/core_decode.sv
source/core_execute.sv
source/core_top.sv
verif/core_tb_top.sv

// File: Makefile
# Verilator build and run for the integer core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= core_tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All checks passed" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/core_tb_top.sv
// ################################################
// Testbench for the integer core
// Instruction memory responder, reference model, checker
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_tb_top;

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  localparam logic [31:0] BOOT_ADDR   = 32'h0000_0080;
  localparam int          PROG_LEN    = 64;
  localparam int          STOP_GRANTS = 48;
  localparam int          TIMEOUT     = 2000;

  logic        clk          = 1'b0;
  logic        rst_n        = 1'b0;
  logic        fetch_enable = 1'b0;
  logic        instr_gnt    = 1'b0;
  logic        instr_rvalid = 1'b0;
  logic [31:0] instr_rdata  = 32'd0;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        retire_valid;
  retire_t     retire;

  logic [31:0] rng_state = 32'd97;
  logic [31:0] model_regs [32] = '{default: '0};
  instr_u      prog [PROG_LEN];
  logic [31:0] rsp_q [$];
  int          grant_count  = 0;
  int          retire_count = 0;

  always #4 clk = ~clk;

  core_top #(
    .BootAddr (BOOT_ADDR),
    .NumRegs  (32)
  ) u_core_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // Upper bits of the state are the better ones
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  function automatic void report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endfunction

  function automatic string fmt_retire(input retire_t t);
    return $sformatf("{order %0d pc %h insn %h trap %b rd %0d wdata %h}",
                     t.order, t.pc, t.insn, t.trap, t.rd_addr, t.rd_wdata);
  endfunction

  task automatic check_retire(input string name, input retire_t want, input retire_t got);
    if (got !== want) begin
      report_failure($sformatf("Mismatch %s: expected %s, actual %s",
                               name, fmt_retire(want), fmt_retire(got)));
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] want,
                            input logic [31:0] got);
    if (got !== want) begin
      report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, want, got));
    end
  endtask

  function automatic instr_u make_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
    instr_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
    return w;
  endfunction

  function automatic instr_u make_i(input logic [11:0] imm, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1);
    instr_u w;
    w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
    return w;
  endfunction

  // Small register range so that neighbours often depend on each other
  function automatic void build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  last_rd;
    logic [2:0]  f3;
    logic [3:0]  kind;
    last_rd = 5'd1;
    for (int n = 0; n < PROG_LEN; n++) begin
      r    = next_random();
      rd   = {2'b00, r[2:0]} + 5'd1;
      rs1  = r[3] ? last_rd : {2'b00, r[6:4]};
      rs2  = r[7] ? last_rd : {1'b0, r[11:8]};
      kind = r[17:14];
      case (r[13:12])
        2'd0:    f3 = F3_ADD;
        2'd1:    f3 = F3_AND;
        2'd2:    f3 = F3_OR;
        default: f3 = F3_XOR;
      endcase
      if (kind == 4'd0) begin
        // Branch opcode is outside the supported subset
        prog[n] = make_r(F7_BASE, f3, rd, rs1, rs2);
        prog[n].r.opcode = 7'b1100011;
      end else if (kind == 4'd1) begin
        prog[n] = make_r(F7_SUB, F3_XOR, rd, rs1, rs2);
      end else if (kind == 4'd2) begin
        prog[n] = make_i(r[30:19], 3'b001, rd, rs1);
      end else if (kind == 4'd3) begin
        // Following words then tend to read x0 right after this write
        prog[n] = make_i(r[30:19], F3_ADD, 5'd0, rs1);
        last_rd = 5'd0;
      end else if (kind < 4'd10) begin
        prog[n] = make_r((f3 == F3_ADD && r[18]) ? F7_SUB : F7_BASE, f3, rd, rs1, rs2);
        last_rd = rd;
      end else begin
        prog[n] = make_i(r[30:19], f3, rd, rs1);
        last_rd = rd;
      end
    end
  endfunction

  // Steps the model register file by one instruction
  function automatic retire_t model_retire(input int idx, input instr_u w);
    retire_t     want;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [2:0]  f3;
    logic        is_sub;
    logic        legal;
    f3     = w.raw[14:12];
    a      = model_regs[w.raw[19:15]];
    b      = (w.raw[6:0] == OPC_OP_IMM) ? {{20{w.raw[31]}}, w.raw[31:20]}
                                        : model_regs[w.raw[24:20]];
    is_sub = (w.raw[6:0] == OPC_OP) && (w.raw[31:25] == F7_SUB);
    legal  = (f3 == F3_ADD) || (f3 == F3_AND) || (f3 == F3_OR) || (f3 == F3_XOR);
    if (w.raw[6:0] == OPC_OP) begin
      legal = legal && (w.raw[31:25] == F7_BASE || (is_sub && f3 == F3_ADD));
    end else if (w.raw[6:0] != OPC_OP_IMM) begin
      legal = 1'b0;
    end
    case (f3)
      F3_ADD:  res = is_sub ? a - b : a + b;
      F3_AND:  res = a & b;
      F3_OR:   res = a | b;
      F3_XOR:  res = a ^ b;
      default: res = 32'd0;
    endcase
    if (!legal) begin
      res = 32'd0;
    end else if (w.raw[11:7] != 5'd0) begin
      model_regs[w.raw[11:7]] = res;
    end
    want.order    = 64'(idx);
    want.pc       = BOOT_ADDR + 32'(idx) * 32'd4;
    want.insn     = w.raw;
    want.trap     = ~legal;
    want.rd_addr  = w.raw[11:7];
    want.rd_wdata = res;
    return want;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    return prog[idx].raw;
  endfunction

  // Memory responder with random grant and rvalid stalls
  always @(posedge clk) begin
    logic [31:0] r;
    r = next_random();
    if (!rst_n) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
    end else begin
      if (instr_req && instr_gnt) begin
        check_addr($sformatf("grant %0d", grant_count),
                   BOOT_ADDR + 32'(grant_count) * 32'd4, instr_addr);
        rsp_q.push_back(instr_addr);
        grant_count <= grant_count + 1;
      end
      instr_gnt <= r[1:0] != 2'b00;
      if (rsp_q.size() > 0 && r[4:2] > 3'd2) begin
        instr_rvalid <= 1'b1;
        instr_rdata  <= mem_word(rsp_q.pop_front());
      end else begin
        instr_rvalid <= 1'b0;
        instr_rdata  <= 32'd0;
      end
    end
  end

  // Retirement checker
  always @(posedge clk) begin
    retire_t want;
    if (rst_n && retire_valid) begin
      if (retire_count >= PROG_LEN) begin
        report_failure("More retirements than program words");
      end else begin
        want = model_retire(retire_count, prog[retire_count]);
        check_retire($sformatf("retire %0d", retire_count), want, retire);
        retire_count <= retire_count + 1;
      end
    end
  end

  initial begin
    int cycles;
    int grants_at_stop;
    build_program();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Core stays quiet until fetch is enabled
    for (int n = 0; n < 4; n++) begin
      @(posedge clk);
      if (instr_req || retire_valid) begin
        report_failure("Request or retirement seen before fetch enable");
      end
    end
    fetch_enable <= 1'b1;

    cycles = 0;
    while (grant_count < STOP_GRANTS) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for instruction grants");
      end
    end
    fetch_enable <= 1'b0;

    // A request already raised may still be granted
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for the request to drop");
      end
    end while (instr_req);
    grants_at_stop = grant_count;

    cycles = 0;
    while (retire_count != grant_count) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for outstanding words to retire");
      end
    end

    for (int n = 0; n < 10; n++) begin
      @(posedge clk);
      if (instr_req || retire_valid || grant_count != grants_at_stop) begin
        report_failure("Fetch or retirement activity after fetch enable dropped");
      end
    end

    if (retire_count == grants_at_stop) begin
      $display("All checks passed");
      $finish;
    end else begin
      report_failure("Retirement count differs from grant count");
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
// ################################################
// Integer core top level
// Fetch, decode, execute and register file
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter logic [31:0] BootAddr = 32'h0000_0080,
  parameter int unsigned NumRegs  = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   fetch_enable_i,
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  output logic [31:0]            instr_addr_o,
  input  logic [31:0]            instr_rdata_i,
  output logic                   retire_valid_o,
  output core_pipe_pkg::retire_t retire_o
);

  import core_pipe_pkg::*;

  logic        item_valid;
  fetch_item_t item;
  logic [4:0]  raddr_a;
  logic [4:0]  raddr_b;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;
  logic        dec_valid;
  decoded_t    dec;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;

  core_fetch #(
    .BootAddr (BootAddr)
  ) u_core_fetch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .item_valid_o   (item_valid),
    .item_o         (item)
  );

  core_decode #(
    .NumRegs (NumRegs)
  ) u_core_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .item_valid_i (item_valid),
    .item_i       (item),
    .raddr_a_o    (raddr_a),
    .raddr_b_o    (raddr_b),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .byp_we_i     (rf_we),
    .byp_addr_i   (rf_waddr),
    .byp_data_i   (rf_wdata),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec)
  );

  core_regfile #(
    .NumRegs (NumRegs)
  ) u_core_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  core_execute u_core_execute (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dec_valid_i    (dec_valid),
    .dec_i          (dec),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

`default_nettype wire

// File: source/core_execute.sv
// ################################################
// Execute and retire stage
// ALU, register writeback and the retirement trace
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_execute (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    dec_valid_i,
  input  core_pipe_pkg::decoded_t dec_i,
  output logic                    rf_we_o,
  output logic [4:0]              rf_waddr_o,
  output logic [31:0]             rf_wdata_o,
  output logic                    retire_valid_o,
  output core_pipe_pkg::retire_t  retire_o
);

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  logic [31:0] alu_result;
  logic [31:0] wdata;
  logic [63:0] order_q;
  retire_t     retire_d;

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD: alu_result = dec_i.operand_a + dec_i.operand_b;
      ALU_SUB: alu_result = dec_i.operand_a - dec_i.operand_b;
      ALU_AND: alu_result = dec_i.operand_a & dec_i.operand_b;
      ALU_OR:  alu_result = dec_i.operand_a | dec_i.operand_b;
      ALU_XOR: alu_result = dec_i.operand_a ^ dec_i.operand_b;
      default: alu_result = '0;
    endcase
  end

  // Traps report no write data
  assign wdata = dec_i.trap ? 32'd0 : alu_result;

  // Write port, also seen by decode as the bypass path
  assign rf_we_o    = dec_valid_i & dec_i.rd_we;
  assign rf_waddr_o = dec_i.rd_addr;
  assign rf_wdata_o = alu_result;

  always_comb begin
    retire_d.order    = order_q;
    retire_d.pc       = dec_i.pc;
    retire_d.insn     = dec_i.insn;
    retire_d.trap     = dec_i.trap;
    retire_d.rd_addr  = dec_i.rd_addr;
    retire_d.rd_wdata = wdata;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      order_q        <= 64'd0;
      retire_valid_o <= 1'b0;
      retire_o       <= '0;
    end else begin
      retire_valid_o <= dec_valid_i;
      if (dec_valid_i) begin
        // Order counts retirements from zero
        order_q  <= order_q + 64'd1;
        retire_o <= retire_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/core_decode.sv
// ################################################
// Decode stage
// Field decode, operand read with bypass, illegal check
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_decode #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       item_valid_i,
  input  core_pipe_pkg::fetch_item_t item_i,
  output logic [4:0]                 raddr_a_o,
  output logic [4:0]                 raddr_b_o,
  input  logic [31:0]                rdata_a_i,
  input  logic [31:0]                rdata_b_i,
  input  logic                       byp_we_i,
  input  logic [4:0]                 byp_addr_i,
  input  logic [31:0]                byp_data_i,
  output logic                       dec_valid_o,
  output core_pipe_pkg::decoded_t    dec_o
);

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  instr_u      insn;
  alu_op_e     alu_op;
  logic        legal_funct;
  logic        regs_ok;
  logic        use_imm;
  logic        illegal;
  logic [4:0]  rd_addr;
  logic [31:0] imm_sext;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  decoded_t    dec_d;

  assign insn      = item_i.insn;
  assign raddr_a_o = insn.r.rs1;
  assign raddr_b_o = insn.r.rs2;
  assign imm_sext  = {{20{insn.i.imm[11]}}, insn.i.imm};

  always_comb begin
    alu_op      = ALU_ADD;
    legal_funct = 1'b0;
    regs_ok     = 1'b1;
    use_imm     = 1'b0;
    rd_addr     = insn.r.rd;
    case (insn.raw[6:0])
      OPC_OP: begin
        regs_ok = insn.r.rs1 < NumRegs && insn.r.rs2 < NumRegs && insn.r.rd < NumRegs;
        legal_funct = 1'b1;
        case ({insn.r.funct7, insn.r.funct3})
          {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
          {F7_SUB,  F3_ADD}: alu_op = ALU_SUB;
          {F7_BASE, F3_AND}: alu_op = ALU_AND;
          {F7_BASE, F3_OR}:  alu_op = ALU_OR;
          {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
          default:           legal_funct = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm     = 1'b1;
        regs_ok     = insn.i.rs1 < NumRegs && insn.i.rd < NumRegs;
        legal_funct = 1'b1;
        case (insn.i.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_AND:  alu_op = ALU_AND;
          F3_OR:   alu_op = ALU_OR;
          F3_XOR:  alu_op = ALU_XOR;
          default: legal_funct = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  assign illegal = ~(legal_funct & regs_ok);

  // Forward the result that execute writes this cycle
  assign rs1_val = (byp_we_i && byp_addr_i == raddr_a_o && raddr_a_o != 5'd0) ?
                   byp_data_i : rdata_a_i;
  assign rs2_val = (byp_we_i && byp_addr_i == raddr_b_o && raddr_b_o != 5'd0) ?
                   byp_data_i : rdata_b_i;

  always_comb begin
    dec_d.pc        = item_i.pc;
    dec_d.insn      = item_i.insn;
    dec_d.alu_op    = alu_op;
    dec_d.operand_a = rs1_val;
    dec_d.operand_b = use_imm ? imm_sext : rs2_val;
    dec_d.rd_addr   = rd_addr;
    dec_d.rd_we     = ~illegal;
    dec_d.trap      = illegal;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= item_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (item_valid_i) begin
      dec_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// File: source/core_regfile.sv
// ################################################
// Register file
// Two async read ports, one write port, x0 tied to zero
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_regfile #(
  parameter int unsigned NumRegs = 32
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        we_i
);

  logic [31:0] regs_q [NumRegs];

  // Zero for x0 and for indices beyond the implemented registers
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    logic [31:0] val;
    val = '0;
    if (addr != 5'd0 && addr < NumRegs) begin
      val = regs_q[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0 && waddr_i < NumRegs) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: source/core_fetch.sv
// ################################################
// Instruction fetch unit
// Drives the req/gnt/rvalid bus, queues returned words
// ################################################
`timescale 1ns/1ps
`default_nettype none

module core_fetch #(
  parameter logic [31:0] BootAddr = 32'h0000_0080
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      fetch_enable_i,
  output logic                      instr_req_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  output logic [31:0]               instr_addr_o,
  input  logic [31:0]               instr_rdata_i,
  output logic                      item_valid_o,
  output core_pipe_pkg::fetch_item_t item_o
);

  import core_pipe_pkg::*;

  logic [31:0] req_pc_q;
  logic [31:0] rsp_pc_q;
  logic [1:0]  outstanding_q;
  logic [1:0]  fill_q;
  logic        pending_q;
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  logic        room;
  logic        grant;
  logic        push;
  logic        pop;

  fetch_item_t queue_q [2];

  // Requests in flight plus queued words never exceed two
  assign room = (outstanding_q + fill_q) < 2'd2;

  // A request that was not granted stays up with the same address
  assign instr_req_o  = pending_q | (fetch_enable_i & room);
  assign instr_addr_o = req_pc_q;

  assign grant = instr_req_o & instr_gnt_i;
  assign push  = instr_rvalid_i;
  assign pop   = fill_q != 2'd0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_pc_q      <= BootAddr;
      rsp_pc_q      <= BootAddr;
      outstanding_q <= 2'd0;
      fill_q        <= 2'd0;
      pending_q     <= 1'b0;
      wr_ptr_q      <= 1'b0;
      rd_ptr_q      <= 1'b0;
      item_valid_o  <= 1'b0;
    end else begin
      if (grant) begin
        req_pc_q <= req_pc_q + 32'd4;
      end
      // Responses return in order, so their PC just steps along
      if (push) begin
        rsp_pc_q <= rsp_pc_q + 32'd4;
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      pending_q     <= instr_req_o & ~instr_gnt_i;
      outstanding_q <= outstanding_q + {1'b0, grant} - {1'b0, push};
      fill_q        <= fill_q + {1'b0, push} - {1'b0, pop};
      item_valid_o  <= pop;
    end
  end

  // Queue storage and output word
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{pc: rsp_pc_q, insn: instr_rdata_i};
    end
    if (pop) begin
      item_o <= queue_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

// File: source/core_pipe_pkg.sv
// ################################################
// Pipeline types for the integer core
// Stage-to-stage records and the retirement trace
// ################################################
`default_nettype none

package core_pipe_pkg;

  // Fetch to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
  } fetch_item_t;

  // Decode to execute, operands already resolved
  typedef struct packed {
    logic [31:0]           pc;
    logic [31:0]           insn;
    core_isa_pkg::alu_op_e alu_op;
    logic [31:0]           operand_a;
    logic [31:0]           operand_b;
    logic [4:0]            rd_addr;
    logic                  rd_we;
    logic                  trap;
  } decoded_t;

  // One record per retired instruction
  typedef struct packed {
    logic [63:0] order;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        trap;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
  } retire_t;

endpackage

`default_nettype wire

// File: source/core_isa_pkg.sv
// ################################################
// ISA definitions for the integer core
// Opcodes, function codes and instruction layouts
// ################################################
`default_nettype none

package core_isa_pkg;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 encodings shared by R and I forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 encodings
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // One fetched word seen through either layout
  typedef union packed {
    instr_r_t    r;
    instr_i_t    i;
    logic [31:0] raw;
  } instr_u;

endpackage

`default_nettype wire
